/* sources.f */
src/adc_rx_pkg.sv
src/frame_align_fsm.sv
src/bit_fill_counter.sv
src/lane_gearbox.sv
src/adc_channel.sv
src/adc_rx_top.sv
verif/adc_rx_checker.sv
verif/adc_rx_tb.sv

/* src/adc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_channel (
  input  wire                          rst,
  input  wire                          lclk_d4,
  input  wire adc_rx_pkg::lane_pair_t   lanes_i,
  input  wire adc_rx_pkg::fill_t        fill_i,
  input  wire                          emit_i,
  output adc_rx_pkg::adc_sample_t       sample_o
);

  adc_rx_pkg::frame_word_t word_a;
  adc_rx_pkg::frame_word_t word_b;
  adc_rx_pkg::adc_sample_t sample_d;
  adc_rx_pkg::adc_sample_t sample_q;

  // Lane A carries the upper half of the sample
  lane_gearbox u_gearbox_a (
    .rst     (rst),
    .lclk_d4 (lclk_d4),
    .nib_i   (lanes_i.lane_a),
    .fill_i  (fill_i),
    .word_o  (word_a)
  );

  // Lane B carries the lower half
  lane_gearbox u_gearbox_b (
    .rst     (rst),
    .lclk_d4 (lclk_d4),
    .nib_i   (lanes_i.lane_b),
    .fill_i  (fill_i),
    .word_o  (word_b)
  );

  always_comb begin
    sample_d.hi = word_a;
    sample_d.lo = word_b;
  end

  // Hold the last sample between emits
  always_ff @(posedge lclk_d4) begin
    if (emit_i) begin
      sample_q <= sample_d;
    end
  end

  assign sample_o = sample_q;

endmodule

`default_nettype wire

/* src/adc_rx_pkg.sv */
`default_nettype none

package adc_rx_pkg;

  // One lane for one lclk_d4 cycle, bit 3 arrives first
  typedef logic [3:0] nibble_t;

  // Five bits of one lane, half a sample, bit 4 arrives first
  typedef logic [4:0] frame_word_t;

  // Count of buffered bits not yet emitted, 0 to 8
  typedef logic [3:0] fill_t;

  // Full 10-bit sample of one channel
  typedef struct packed {
    // Sample bits 9..5 from lane A
    frame_word_t hi;
    // Sample bits 4..0 from lane B
    frame_word_t lo;
  } adc_sample_t;

  // Both lanes of one channel for one cycle
  typedef struct packed {
    nibble_t lane_a;
    nibble_t lane_b;
  } lane_pair_t;

  // Frame clock across one sample period
  // High for three bit times, then low for two
  localparam frame_word_t FRAME_PATTERN = 5'b11100;

  // Bits per word and bits per nibble
  localparam int WORD_BITS = 5;
  localparam int NIB_BITS  = 4;

  // Aligner states
  typedef enum logic [1:0] {
    ALIGN_IDLE   = 2'd0,
    ALIGN_HUNT   = 2'd1,
    ALIGN_LOCKED = 2'd2
  } align_state_t;

endpackage

`default_nettype wire

/* src/adc_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_top #(
  parameter int NUM_CH = 4
) (
  input  wire                          rst,
  input  wire                          lclk_d4,
  input  wire                          sync_i,
  input  wire adc_rx_pkg::nibble_t      fclk_i,
  input  wire adc_rx_pkg::lane_pair_t   lanes_i [NUM_CH],
  output logic                         locked_o,
  output logic                         sample_valid_o,
  output adc_rx_pkg::adc_sample_t       samples_o [NUM_CH]
);

  logic                    load;
  adc_rx_pkg::fill_t       load_fill;
  adc_rx_pkg::fill_t       fill;
  logic                    word_done;
  adc_rx_pkg::frame_word_t frame_word;
  logic                    emit;
  logic                    sample_valid_q;

  frame_align_fsm u_align (
    .rst          (rst),
    .lclk_d4      (lclk_d4),
    .sync_i       (sync_i),
    .fclk_nib_i   (fclk_i),
    .frame_word_i (frame_word),
    .word_done_i  (word_done),
    .load_o       (load),
    .load_fill_o  (load_fill),
    .emit_o       (emit),
    .locked_o     (locked_o)
  );

  // One bit phase shared by all lanes
  bit_fill_counter u_fill (
    .rst         (rst),
    .lclk_d4     (lclk_d4),
    .load_i      (load),
    .load_fill_i (load_fill),
    .fill_o      (fill),
    .word_done_o (word_done)
  );

  // Frame clock lane, same regrouping as the data lanes
  lane_gearbox u_fclk_gearbox (
    .rst     (rst),
    .lclk_d4 (lclk_d4),
    .nib_i   (fclk_i),
    .fill_i  (fill),
    .word_o  (frame_word)
  );

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    adc_channel u_channel (
      .rst      (rst),
      .lclk_d4  (lclk_d4),
      .lanes_i  (lanes_i[ch]),
      .fill_i   (fill),
      .emit_i   (emit),
      .sample_o (samples_o[ch])
    );
  end

  // Valid lines up with the channel sample registers
  always_ff @(posedge lclk_d4) begin
    if (rst) begin
      sample_valid_q <= 1'b0;
    end else begin
      sample_valid_q <= emit;
    end
  end

  assign sample_valid_o = sample_valid_q;

endmodule

`default_nettype wire

/* src/bit_fill_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_fill_counter (
  input  wire                    rst,
  input  wire                    lclk_d4,
  input  wire                    load_i,
  input  wire adc_rx_pkg::fill_t load_fill_i,
  output adc_rx_pkg::fill_t      fill_o,
  output logic                   word_done_o
);

  adc_rx_pkg::fill_t fill_q;
  adc_rx_pkg::fill_t fill_d;
  adc_rx_pkg::fill_t fill_sum;

  // Four new bits arrive every cycle
  assign fill_sum = fill_q + adc_rx_pkg::fill_t'(adc_rx_pkg::NIB_BITS);

  // A word completes once five bits are held, never on a load
  assign word_done_o = !load_i && (fill_sum >= adc_rx_pkg::fill_t'(adc_rx_pkg::WORD_BITS));

  always_comb begin
    if (load_i) begin
      fill_d = load_fill_i;
    end else if (word_done_o) begin
      fill_d = fill_sum - adc_rx_pkg::fill_t'(adc_rx_pkg::WORD_BITS);
    end else begin
      fill_d = fill_sum;
    end
  end

  always_ff @(posedge lclk_d4) begin
    if (rst) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  // Bits held before this cycle's nibble
  assign fill_o = fill_q;

endmodule

`default_nettype wire

/* src/frame_align_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_align_fsm (
  input  wire                         rst,
  input  wire                         lclk_d4,
  input  wire                         sync_i,
  input  wire adc_rx_pkg::nibble_t     fclk_nib_i,
  input  wire adc_rx_pkg::frame_word_t frame_word_i,
  input  wire                         word_done_i,
  output logic                        load_o,
  output adc_rx_pkg::fill_t           load_fill_o,
  output logic                        emit_o,
  output logic                        locked_o
);

  adc_rx_pkg::align_state_t state_q;
  adc_rx_pkg::align_state_t state_d;
  logic       sync_q1;
  logic       sync_q2;
  logic       sync_rise;
  logic       fclk_last_q;
  logic [4:0] fclk_stream;
  logic       edge_found;
  logic [1:0] edge_pos;
  logic       armed_q;
  logic       word_match;

  // Two-flop synchronizer on the sync level
  always_ff @(posedge lclk_d4) begin
    if (rst) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= sync_i;
      sync_q2 <= sync_q1;
    end
  end

  assign sync_rise = sync_q1 & ~sync_q2;

  // Last frame bit of the previous cycle
  always_ff @(posedge lclk_d4) begin
    fclk_last_q <= fclk_nib_i[0];
  end

  assign fclk_stream = {fclk_last_q, fclk_nib_i};

  // Earliest rising edge of the frame clock within this nibble
  always_comb begin
    edge_found = 1'b0;
    edge_pos   = 2'd0;
    for (int p = 3; p >= 0; p--) begin
      if (!fclk_stream[4 - p] && fclk_stream[3 - p]) begin
        edge_found = 1'b1;
        edge_pos   = 2'(p);
      end
    end
  end

  assign word_match  = (frame_word_i == adc_rx_pkg::FRAME_PATTERN);
  assign load_o      = (state_q == adc_rx_pkg::ALIGN_HUNT) && !armed_q && edge_found;
  // Keep only the bits from the edge onwards
  assign load_fill_o = 4'd4 - {2'b00, edge_pos};
  assign emit_o      = (state_q == adc_rx_pkg::ALIGN_LOCKED) && word_done_i && word_match;
  assign locked_o    = (state_q == adc_rx_pkg::ALIGN_LOCKED);

  always_comb begin
    state_d = state_q;
    case (state_q)
      adc_rx_pkg::ALIGN_IDLE: begin
        if (sync_rise) begin
          state_d = adc_rx_pkg::ALIGN_HUNT;
        end
      end
      adc_rx_pkg::ALIGN_HUNT: begin
        // First word after the load decides
        if (armed_q && word_done_i && word_match) begin
          state_d = adc_rx_pkg::ALIGN_LOCKED;
        end
      end
      adc_rx_pkg::ALIGN_LOCKED: begin
        if (word_done_i && !word_match) begin
          state_d = adc_rx_pkg::ALIGN_HUNT;
        end
      end
      default: state_d = adc_rx_pkg::ALIGN_IDLE;
    endcase
  end

  always_ff @(posedge lclk_d4) begin
    if (rst) begin
      state_q <= adc_rx_pkg::ALIGN_IDLE;
      armed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_o) begin
        armed_q <= 1'b1;
      end else if (armed_q && word_done_i) begin
        armed_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/lane_gearbox.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_gearbox (
  input  wire                       rst,
  input  wire                       lclk_d4,
  input  wire adc_rx_pkg::nibble_t   nib_i,
  input  wire adc_rx_pkg::fill_t     fill_i,
  output adc_rx_pkg::frame_word_t    word_o
);

  logic [11:0] hist_q;
  logic [16:0] ext_w;

  // Shift history, newest nibble in the low bits
  always_ff @(posedge lclk_d4) begin
    if (rst) begin
      hist_q <= '0;
    end else begin
      hist_q <= {hist_q[7:0], nib_i};
    end
  end

  // History plus current nibble, padded by one so fill zero stays in range
  assign ext_w = {hist_q, nib_i, 1'b0};

  // Oldest five buffered bits sit at fill+3 down to fill-1 of history and nibble
  assign word_o = ext_w[fill_i +: 5];

endmodule

`default_nettype wire

/* verif/adc_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_checker (
  input wire rst,
  input wire lclk_d4,
  input wire locked_i,
  input wire sample_valid_i
);

  // Failed assertions so far
  int fail_count = 0;

  // A sample only comes out of a word taken while locked
  a_valid_after_lock : assert property (
    @(posedge lclk_d4) disable iff (rst)
    sample_valid_i |-> $past(locked_i)
  ) else begin
    $error("sample_valid_o without lock in the previous cycle");
    fail_count++;
  end

  // Nothing valid in reset or right after it
  a_quiet_after_reset : assert property (
    @(posedge lclk_d4)
    $past(rst) |-> !sample_valid_i
  ) else begin
    $error("sample_valid_o high in or just after reset");
    fail_count++;
  end

  // Four words in five cycles leave one gap in every five
  a_rate_limit : assert property (
    @(posedge lclk_d4) disable iff (rst)
    sample_valid_i [*4] |=> !sample_valid_i
  ) else begin
    $error("sample_valid_o high for five consecutive cycles");
    fail_count++;
  end

endmodule

bind adc_rx_top adc_rx_checker u_checker (
  .rst            (rst),
  .lclk_d4        (lclk_d4),
  .locked_i       (locked_o),
  .sample_valid_i (sample_valid_o)
);

`default_nettype wire

/* verif/adc_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_tb;

  localparam int NUM_CH = 4;
  localparam int NUM_FRAMES = 40;
  localparam int SLIP_F = 20;
  localparam int SYNC_N = 6;
  localparam int RESYNC_N = 40;
  localparam int DRAIN = 8;
  // Seven runs of reset, at most 51 nibbles and the drain
  localparam int STIM_CYCLES = 7 * (4 + 51 + DRAIN);
  localparam int LIMIT = STIM_CYCLES + 50;

  logic rst;
  logic lclk_d4;
  logic sync_i;
  adc_rx_pkg::nibble_t fclk_i;
  adc_rx_pkg::lane_pair_t lanes_i [NUM_CH];
  logic locked_o;
  logic sample_valid_o;
  adc_rx_pkg::adc_sample_t samples_o [NUM_CH];

  bit fbits [0:1023];
  bit lbits [0:2*NUM_CH-1][0:1023];
  int fstart [0:NUM_FRAMES-1];
  logic [10*NUM_CH-1:0] frame_smp [0:NUM_FRAMES-1];
  logic [10*NUM_CH-1:0] exp_q [$];
  logic [31:0] lcg_state = 32'd23;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int falls = 0;
  logic pre_sync = 1'b0;
  logic streaming = 1'b0;
  logic prev_locked = 1'b0;

  adc_rx_top #(.NUM_CH(NUM_CH)) dut (
    .rst            (rst),
    .lclk_d4        (lclk_d4),
    .sync_i         (sync_i),
    .fclk_i         (fclk_i),
    .lanes_i        (lanes_i),
    .locked_o       (locked_o),
    .sample_valid_o (sample_valid_o),
    .samples_o      (samples_o)
  );

  initial begin
    lclk_d4 = 1'b0;
    forever #4 lclk_d4 = ~lclk_d4;
  end

  function automatic logic [9:0] lcg_sample();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[25:16];
  endfunction

  // Lock frame is the first whole frame starting once HUNT runs
  // Emission starts with the frame after it
  task automatic queue_frames(input int first_f, input int last_f, input int hunt_c);
    int lock_f;
    lock_f = -1;
    for (int f = first_f; f <= last_f; f++) begin
      if (lock_f < 0) begin
        if (fstart[f] >= 0 && fstart[f] / 4 >= hunt_c) begin
          lock_f = f;
        end
      end else begin
        exp_q.push_back(frame_smp[f]);
      end
    end
  endtask

  task automatic run_case(input int off, input int slip_k);
    int nbits;
    int slip_pos;
    int nnib;
    int pos;
    logic [9:0] s;
    nbits = 0;
    slip_pos = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      // Slip inserts zero bits into every lane at a frame boundary
      if (slip_k > 0 && f == SLIP_F) begin
        slip_pos = nbits - off;
        for (int b = 0; b < slip_k; b++) begin
          fbits[nbits] = 1'b0;
          for (int l = 0; l < 2 * NUM_CH; l++) lbits[l][nbits] = 1'b0;
          nbits++;
        end
      end
      fstart[f] = nbits - off;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        s = lcg_sample();
        frame_smp[f][ch*10 +: 10] = s;
        for (int b = 0; b < 5; b++) begin
          lbits[2*ch][nbits + b] = s[9 - b];
          lbits[2*ch + 1][nbits + b] = s[4 - b];
        end
      end
      for (int b = 0; b < 5; b++) fbits[nbits + b] = adc_rx_pkg::FRAME_PATTERN[4 - b];
      nbits += 5;
    end
    nnib = (nbits - off + 3) / 4;
    exp_q.delete();
    if (slip_k > 0) begin
      queue_frames(0, SLIP_F - 1, SYNC_N + 2);
      // The word spanning the slip fails and HUNT starts the cycle after it
      queue_frames(SLIP_F, NUM_FRAMES - 1, (slip_pos + 4) / 4 + 1);
    end else begin
      queue_frames(0, NUM_FRAMES - 1, SYNC_N + 2);
    end
    rst = 1'b1;
    sync_i = 1'b0;
    fclk_i = '0;
    for (int ch = 0; ch < NUM_CH; ch++) lanes_i[ch] = '0;
    repeat (4) @(posedge lclk_d4);
    #1 rst = 1'b0;
    falls = 0;
    for (int n = 0; n < nnib + DRAIN; n++) begin
      @(posedge lclk_d4);
      #1;
      pre_sync = (n <= SYNC_N + 2);
      streaming = (n < nnib);
      sync_i = (n >= SYNC_N) && !(n >= RESYNC_N && n < RESYNC_N + 2);
      for (int j = 0; j < 4; j++) begin
        pos = off + 4 * n + j;
        fclk_i[3 - j] = (pos < nbits) ? fbits[pos] : 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
          lanes_i[ch].lane_a[3 - j] = (pos < nbits) ? lbits[2*ch][pos] : 1'b0;
          lanes_i[ch].lane_b[3 - j] = (pos < nbits) ? lbits[2*ch + 1][pos] : 1'b0;
        end
      end
      if (n == nnib - 1) begin
        @(negedge lclk_d4);
        checks++;
        assert (locked_o) else begin
          $display("** Error @ %0t: not locked at end of stream, offset %0d", $time, off);
          errors++;
        end
      end
    end
    @(negedge lclk_d4);
    checks += 2;
    assert (exp_q.size() == 0) else begin
      $display("** Error @ %0t: %0d expected samples never came", $time, exp_q.size());
      errors++;
    end
    assert (falls == ((slip_k > 0) ? 1 : 0)) else begin
      $display("** Error @ %0t: lock dropped %0d times, slip %0d", $time, falls, slip_k);
      errors++;
    end
  endtask

  always @(negedge lclk_d4) begin : scoreboard
    logic [10*NUM_CH-1:0] head;
    if (!rst) begin
      if (pre_sync) begin
        checks++;
        assert (!locked_o && !sample_valid_o) else begin
          $display("** Error @ %0t: lock or valid active before sync", $time);
          errors++;
        end
      end
      if (streaming && prev_locked && !locked_o) falls++;
      if (sample_valid_o) begin
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("** Error @ %0t: sample emitted with none expected", $time);
          errors++;
        end
        if (exp_q.size() > 0) begin
          head = exp_q.pop_front();
          for (int ch = 0; ch < NUM_CH; ch++) begin
            assert (samples_o[ch] == head[ch*10 +: 10]) else begin
              $display("** Error @ %0t: ch%0d sample %h expected %h", $time, ch,
                       samples_o[ch], head[ch*10 +: 10]);
              errors++;
            end
          end
        end
      end
    end
    prev_locked = locked_o;
  end

  always @(posedge lclk_d4) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    sync_i = 1'b0;
    fclk_i = '0;
    for (int ch = 0; ch < NUM_CH; ch++) lanes_i[ch] = '0;
    for (int off = 0; off < 4; off++) run_case(off, 0);
    for (int k = 1; k <= 3; k++) run_case(k, k);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut.u_checker.fail_count);
    if (errors == 0 && dut.u_checker.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
